// ==== Bender.yml ====
package:
  name: mmio_afu

sources:
  - files:
      - src/mmio_pkg.sv
      - src/mmio_req_split.sv
      - src/mmio_avmm64_bridge.sv
      - src/mmio_avmm512_wr_bridge.sv
      - src/afu_csr_bank.sv
      - src/mmio_rsp_encode.sv
      - src/mmio_afu_top.sv
  - target: test
    files:
      - verification/mmio_afu_tb.sv

// ==== sim.f ====
src/mmio_pkg.sv
src/mmio_req_split.sv
src/mmio_avmm64_bridge.sv
src/mmio_avmm512_wr_bridge.sv
src/afu_csr_bank.sv
src/mmio_rsp_encode.sv
src/mmio_afu_top.sv
verification/mmio_afu_tb.sv

// ==== src/afu_csr_bank.sv ====
// AFU CSR bank
// ID register, read/write scratch CSRs and a 512-bit line window that
// reads back as quadwords, with a fixed one-cycle read latency

module afu_csr_bank #(
    parameter int NUM_CSRS = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  av_read,
    input  logic                  av_write,
    input  mmio_pkg::mmio_addr_t  av_address,
    input  mmio_pkg::mmio_qword_t av_writedata,
    output mmio_pkg::mmio_qword_t av_readdata,
    output logic                  av_readdatavalid,
    input  logic                  line_we,
    input  mmio_pkg::mmio_line_u  line_data
);

    localparam int CSR_IDX_W = $clog2(NUM_CSRS);

    // CSR 0 is the constant ID, so storage starts at index 1
    mmio_pkg::mmio_qword_t csr_q [1:NUM_CSRS-1];
    mmio_pkg::mmio_line_u  line_q;
    mmio_pkg::mmio_qword_t rd_mux;
    logic                  in_csr;
    logic                  in_line;

    // ====================
    // Address decode
    // ====================

    assign in_csr  = av_address < mmio_pkg::mmio_addr_t'(NUM_CSRS);
    assign in_line = (av_address >= mmio_pkg::LINE_BASE) &&
                     (av_address < mmio_pkg::LINE_BASE + mmio_pkg::QWORDS_PER_LINE);

    // ====================
    // Storage
    // ====================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_CSRS; i++) begin
                csr_q[i] <= '0;
            end
            line_q <= '0;
        end else begin
            // Writes to the ID register and to the line window are dropped
            if (av_write && in_csr && (av_address != '0)) begin
                csr_q[av_address[CSR_IDX_W-1:0]] <= av_writedata;
            end
            if (line_we) begin
                line_q <= line_data;
            end
        end
    end

    // ====================
    // Read path
    // ====================

    always_comb begin
        rd_mux = '0;
        if (in_csr) begin
            rd_mux = (av_address == '0) ? mmio_pkg::AFU_ID : csr_q[av_address[CSR_IDX_W-1:0]];
        end else if (in_line) begin
            // The line base is aligned, so the low bits pick the quadword
            rd_mux = line_q.qwords[av_address[mmio_pkg::LINE_QW_BITS-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            av_readdatavalid <= 1'b0;
        end else begin
            av_readdatavalid <= av_read;
        end
    end

    // Read data is only looked at with av_readdatavalid
    always_ff @(posedge clk) begin
        if (av_read) begin
            av_readdata <= rd_mux;
        end
    end

endmodule

// ==== src/mmio_afu_top.sv ====
// MMIO AFU front end
// Host requests are split by length, mapped onto a 64-bit Avalon bridge
// or a write-only 512-bit bridge, served by one CSR bank and answered
// through the response encoder

module mmio_afu_top #(
    parameter int NUM_CSRS           = 16,
    parameter int MAX_OUTSTANDING_RD = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  logic                  req_write,
    input  logic                  req_is512,
    input  mmio_pkg::mmio_addr_t  req_addr,
    input  mmio_pkg::mmio_tid_t   req_tid,
    input  mmio_pkg::mmio_line_u  req_data,
    output logic                  rsp_valid,
    output mmio_pkg::mmio_tid_t   rsp_tid,
    output mmio_pkg::mmio_qword_t rsp_data,
    output logic                  bad_len_err,
    output logic                  misalign_err
);

    // ====================
    // Splitter outputs
    // ====================

    logic                  m64_valid;
    logic                  m64_write;
    mmio_pkg::mmio_addr_t  m64_addr;
    mmio_pkg::mmio_tid_t   m64_tid;
    mmio_pkg::mmio_qword_t m64_data;
    logic                  m512_valid;
    mmio_pkg::mmio_addr_t  m512_addr;
    mmio_pkg::mmio_line_u  m512_data;

    // ====================
    // Bridge and bank wires
    // ====================

    logic                  av_read;
    logic                  av_write;
    mmio_pkg::mmio_addr_t  av_address;
    mmio_pkg::mmio_qword_t av_writedata;
    mmio_pkg::mmio_qword_t av_readdata;
    logic                  av_readdatavalid;
    logic                  line_we;
    mmio_pkg::mmio_line_u  line_data;
    logic                  rd_valid;
    mmio_pkg::mmio_tid_t   rd_tid;
    mmio_pkg::mmio_qword_t rd_data;

    // Input side
    mmio_req_split u_req_split (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_write   (req_write),
        .req_is512   (req_is512),
        .req_addr    (req_addr),
        .req_tid     (req_tid),
        .req_data    (req_data),
        .m64_valid   (m64_valid),
        .m64_write   (m64_write),
        .m64_addr    (m64_addr),
        .m64_tid     (m64_tid),
        .m64_data    (m64_data),
        .m512_valid  (m512_valid),
        .m512_addr   (m512_addr),
        .m512_data   (m512_data),
        .bad_len_err (bad_len_err)
    );

    // 64-bit path, reads and writes
    mmio_avmm64_bridge #(
        .MAX_OUTSTANDING_RD (MAX_OUTSTANDING_RD)
    ) u_avmm64_bridge (
        .clk              (clk),
        .rst_n            (rst_n),
        .m64_valid        (m64_valid),
        .m64_write        (m64_write),
        .m64_addr         (m64_addr),
        .m64_tid          (m64_tid),
        .m64_data         (m64_data),
        .av_read          (av_read),
        .av_write         (av_write),
        .av_address       (av_address),
        .av_writedata     (av_writedata),
        .av_readdata      (av_readdata),
        .av_readdatavalid (av_readdatavalid),
        .rd_valid         (rd_valid),
        .rd_tid           (rd_tid),
        .rd_data          (rd_data)
    );

    // 512-bit path, writes only
    mmio_avmm512_wr_bridge u_avmm512_wr_bridge (
        .clk          (clk),
        .rst_n        (rst_n),
        .m512_valid   (m512_valid),
        .m512_addr    (m512_addr),
        .m512_data    (m512_data),
        .line_we      (line_we),
        .line_data    (line_data),
        .misalign_err (misalign_err)
    );

    afu_csr_bank #(
        .NUM_CSRS (NUM_CSRS)
    ) u_csr_bank (
        .clk              (clk),
        .rst_n            (rst_n),
        .av_read          (av_read),
        .av_write         (av_write),
        .av_address       (av_address),
        .av_writedata     (av_writedata),
        .av_readdata      (av_readdata),
        .av_readdatavalid (av_readdatavalid),
        .line_we          (line_we),
        .line_data        (line_data)
    );

    // Output side
    mmio_rsp_encode u_rsp_encode (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_valid  (rd_valid),
        .rd_tid    (rd_tid),
        .rd_data   (rd_data),
        .rsp_valid (rsp_valid),
        .rsp_tid   (rsp_tid),
        .rsp_data  (rsp_data)
    );

endmodule

// ==== src/mmio_avmm512_wr_bridge.sv ====
// Write-only 512-bit MMIO bridge
// Checks line alignment and turns a write at the line window base
// into a line write toward the CSR bank

module mmio_avmm512_wr_bridge (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 m512_valid,
    input  mmio_pkg::mmio_addr_t m512_addr,
    input  mmio_pkg::mmio_line_u m512_data,
    output logic                 line_we,
    output mmio_pkg::mmio_line_u line_data,
    output logic                 misalign_err
);

    logic misaligned;

    // Low address bits select a quadword inside a line
    assign misaligned = |m512_addr[mmio_pkg::LINE_QW_BITS-1:0];

    // The bank stores the line at the next edge, which keeps 512-bit
    // writes at the same depth as 64-bit writes
    assign line_we   = m512_valid && (m512_addr == mmio_pkg::LINE_BASE);
    assign line_data = m512_data;

    // Aligned lines outside the window fall through with no error
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            misalign_err <= 1'b0;
        end else begin
            misalign_err <= m512_valid && misaligned;
        end
    end

endmodule

// ==== src/mmio_avmm64_bridge.sv ====
// 64-bit MMIO to Avalon bridge
// Turns request strobes into Avalon reads and writes and pairs returning
// read data with the transaction ids of the reads, oldest first

module mmio_avmm64_bridge #(
    parameter int MAX_OUTSTANDING_RD = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  m64_valid,
    input  logic                  m64_write,
    input  mmio_pkg::mmio_addr_t  m64_addr,
    input  mmio_pkg::mmio_tid_t   m64_tid,
    input  mmio_pkg::mmio_qword_t m64_data,
    output logic                  av_read,
    output logic                  av_write,
    output mmio_pkg::mmio_addr_t  av_address,
    output mmio_pkg::mmio_qword_t av_writedata,
    input  mmio_pkg::mmio_qword_t av_readdata,
    input  logic                  av_readdatavalid,
    output logic                  rd_valid,
    output mmio_pkg::mmio_tid_t   rd_tid,
    output mmio_pkg::mmio_qword_t rd_data
);

    localparam int PTR_W = (MAX_OUTSTANDING_RD > 1) ? $clog2(MAX_OUTSTANDING_RD) : 1;

    // Tid FIFO, one entry per read in flight toward the CSR bank
    mmio_pkg::mmio_tid_t tid_fifo [MAX_OUTSTANDING_RD];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;

    // ====================
    // Avalon request side
    // ====================

    // The bank has fixed latency, so requests issue in the strobe cycle
    assign av_read      = m64_valid && !m64_write;
    assign av_write     = m64_valid && m64_write;
    assign av_address   = m64_addr;
    assign av_writedata = m64_data;

    // Pointers wrap at the queue depth, which need not be a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (av_read) begin
                wr_ptr <= (wr_ptr == PTR_W'(MAX_OUTSTANDING_RD - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (av_readdatavalid) begin
                rd_ptr <= (rd_ptr == PTR_W'(MAX_OUTSTANDING_RD - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // Storage holds only payload, the pointers say what is valid
    always_ff @(posedge clk) begin
        if (av_read) begin
            tid_fifo[wr_ptr] <= m64_tid;
        end
    end

    // ====================
    // Read completion side
    // ====================

    // Data returns in request order, so the head entry is its tid
    assign rd_valid = av_readdatavalid;
    assign rd_tid   = tid_fifo[rd_ptr];
    assign rd_data  = av_readdata;

endmodule

// ==== src/mmio_pkg.sv ====
// MMIO shared definitions
// Widths, transaction id and address types, and the 512-bit data word
// that is decoded either as a full line or as eight quadwords

package mmio_pkg;

    // ====================
    // Widths
    // ====================

    localparam int QWORD_W         = 64;
    localparam int QWORDS_PER_LINE = 8;
    localparam int LINE_W          = QWORD_W * QWORDS_PER_LINE;
    localparam int LINE_QW_BITS    = $clog2(QWORDS_PER_LINE);
    localparam int TID_W           = 9;
    localparam int ADDR_W          = 16;

    // ====================
    // Types
    // ====================

    typedef logic [QWORD_W-1:0] mmio_qword_t;
    typedef logic [TID_W-1:0]   mmio_tid_t;

    // Quadword address, not a byte address
    typedef logic [ADDR_W-1:0]  mmio_addr_t;

    // One 512-bit MMIO data word
    // Quadword 0 sits in the low bits, so a 64-bit write uses qwords[0]
    typedef union packed {
        logic [LINE_W-1:0]                 line;
        mmio_qword_t [QWORDS_PER_LINE-1:0] qwords;
    } mmio_line_u;

    // ====================
    // CSR map
    // ====================

    // Value returned by CSR 0
    localparam mmio_qword_t AFU_ID = 64'h8a3f_51c2_d7e0_4b69;

    // First quadword of the 512-bit line window
    localparam mmio_addr_t LINE_BASE = 16'd16;

endpackage

// ==== src/mmio_req_split.sv ====
// MMIO request splitter
// Registers host requests and steers them by length to the 64-bit path
// or the write-only 512-bit path, flagging 512-bit reads as illegal

module mmio_req_split (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  logic                  req_write,
    input  logic                  req_is512,
    input  mmio_pkg::mmio_addr_t  req_addr,
    input  mmio_pkg::mmio_tid_t   req_tid,
    input  mmio_pkg::mmio_line_u  req_data,
    output logic                  m64_valid,
    output logic                  m64_write,
    output mmio_pkg::mmio_addr_t  m64_addr,
    output mmio_pkg::mmio_tid_t   m64_tid,
    output mmio_pkg::mmio_qword_t m64_data,
    output logic                  m512_valid,
    output mmio_pkg::mmio_addr_t  m512_addr,
    output mmio_pkg::mmio_line_u  m512_data,
    output logic                  bad_len_err
);

    // Payload is shared by both paths, only the strobes are steered
    mmio_pkg::mmio_addr_t addr_q;
    mmio_pkg::mmio_tid_t  tid_q;
    mmio_pkg::mmio_line_u data_q;
    logic                 write_q;

    // Strobes and the error pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m64_valid   <= 1'b0;
            m512_valid  <= 1'b0;
            bad_len_err <= 1'b0;
        end else begin
            m64_valid   <= req_valid && !req_is512;
            m512_valid  <= req_valid && req_is512 && req_write;
            // A 512-bit read has no path, so it is dropped here
            bad_len_err <= req_valid && req_is512 && !req_write;
        end
    end

    // Request fields, captured only when a request arrives
    always_ff @(posedge clk) begin
        if (req_valid) begin
            addr_q  <= req_addr;
            tid_q   <= req_tid;
            data_q  <= req_data;
            write_q <= req_write;
        end
    end

    assign m64_write = write_q;
    assign m64_addr  = addr_q;
    assign m64_tid   = tid_q;
    // A 64-bit write carries its data in quadword 0
    assign m64_data  = data_q.qwords[0];

    assign m512_addr = addr_q;
    assign m512_data = data_q;

endmodule

// ==== src/mmio_rsp_encode.sv ====
// MMIO response encoder
// Registers each completed read onto the host response port

module mmio_rsp_encode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rd_valid,
    input  mmio_pkg::mmio_tid_t   rd_tid,
    input  mmio_pkg::mmio_qword_t rd_data,
    output logic                  rsp_valid,
    output mmio_pkg::mmio_tid_t   rsp_tid,
    output mmio_pkg::mmio_qword_t rsp_data
);

    // The strobe drops in any cycle with no completion
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rd_valid;
        end
    end

    // Tid and data hold their last value between responses
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            rsp_tid  <= rd_tid;
            rsp_data <= rd_data;
        end
    end

endmodule

// ==== verification/mmio_afu_tb.sv ====
// Testbench for the MMIO AFU front end
// Drives directed and random host requests and checks responses and
// error pulses against a CSR and line model kept here

module mmio_afu_tb;

    localparam int NUM_CSRS  = 16;
    localparam int N_RANDOM  = 300;
    localparam int DRAIN_MAX = 50;

    typedef enum {ERR_BAD_LEN, ERR_MISALIGN} err_kind_e;

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid;
    logic                  req_write;
    logic                  req_is512;
    mmio_pkg::mmio_addr_t  req_addr;
    mmio_pkg::mmio_tid_t   req_tid;
    mmio_pkg::mmio_line_u  req_data;
    logic                  rsp_valid;
    mmio_pkg::mmio_tid_t   rsp_tid;
    mmio_pkg::mmio_qword_t rsp_data;
    logic                  bad_len_err;
    logic                  misalign_err;

    // ====================
    // Model state
    // ====================

    mmio_pkg::mmio_qword_t csr_m [NUM_CSRS];
    mmio_pkg::mmio_line_u  line_m;
    mmio_pkg::mmio_tid_t   next_tid;
    int unsigned           cyc;

    // Expected read responses, oldest first, with the cycle they are due
    mmio_pkg::mmio_tid_t   exp_tid_q [$];
    mmio_pkg::mmio_qword_t exp_data_q [$];
    int unsigned           exp_cyc_q [$];
    int unsigned           bad_cyc_q [$];
    int unsigned           mis_cyc_q [$];

    mmio_afu_top #(
        .NUM_CSRS           (NUM_CSRS),
        .MAX_OUTSTANDING_RD (4)
    ) uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_write    (req_write),
        .req_is512    (req_is512),
        .req_addr     (req_addr),
        .req_tid      (req_tid),
        .req_data     (req_data),
        .rsp_valid    (rsp_valid),
        .rsp_tid      (rsp_tid),
        .rsp_data     (rsp_data),
        .bad_len_err  (bad_len_err),
        .misalign_err (misalign_err)
    );

    always #5 clk = ~clk;

    // Edge counter, read at a rising edge it still holds the previous count
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run stopped at first error");
    endtask

    // ====================
    // Compare tasks
    // ====================

    task automatic check_rsp(input mmio_pkg::mmio_tid_t tid, input mmio_pkg::mmio_qword_t data);
        mmio_pkg::mmio_tid_t   exp_tid;
        mmio_pkg::mmio_qword_t exp_data;
        int unsigned           exp_cyc;
        if (exp_tid_q.size() == 0) begin
            abort_run($sformatf("error at %0t: response arrived with no read outstanding", $time));
        end else begin
            exp_tid  = exp_tid_q.pop_front();
            exp_data = exp_data_q.pop_front();
            exp_cyc  = exp_cyc_q.pop_front();
            if (exp_cyc != cyc) begin
                abort_run($sformatf("mismatch at %0t: rsp_valid cycle expected %0d got %0d",
                                    $time, exp_cyc, cyc));
            end else if (tid !== exp_tid) begin
                abort_run($sformatf("mismatch at %0t: rsp_tid expected %h got %h",
                                    $time, exp_tid, tid));
            end else if (data !== exp_data) begin
                abort_run($sformatf("mismatch at %0t: rsp_data expected %h got %h",
                                    $time, exp_data, data));
            end
        end
    endtask

    task automatic check_err(input err_kind_e kind, input int unsigned seen_cyc);
        string       name;
        int unsigned exp_cyc;
        name = (kind == ERR_BAD_LEN) ? "bad_len_err" : "misalign_err";
        if ((kind == ERR_BAD_LEN) ? (bad_cyc_q.size() == 0) : (mis_cyc_q.size() == 0)) begin
            abort_run($sformatf("error at %0t: %s pulsed with no error expected", $time, name));
        end else begin
            exp_cyc = (kind == ERR_BAD_LEN) ? bad_cyc_q.pop_front() : mis_cyc_q.pop_front();
            if (exp_cyc != seen_cyc) begin
                abort_run($sformatf("mismatch at %0t: %s cycle expected %0d got %0d",
                                    $time, name, exp_cyc, seen_cyc));
            end
        end
    endtask

    // Outputs change just after the rising edge, so they are sampled at the falling one
    always @(negedge clk) begin
        if (rst_n) begin
            if (rsp_valid) begin
                check_rsp(rsp_tid, rsp_data);
            end else if (exp_cyc_q.size() > 0 && exp_cyc_q[0] <= cyc) begin
                abort_run($sformatf("error at %0t: read response did not arrive", $time));
            end
            if (bad_len_err) begin
                check_err(ERR_BAD_LEN, cyc);
            end else if (bad_cyc_q.size() > 0 && bad_cyc_q[0] <= cyc) begin
                abort_run($sformatf("error at %0t: bad_len_err pulse is missing", $time));
            end
            if (misalign_err) begin
                check_err(ERR_MISALIGN, cyc);
            end else if (mis_cyc_q.size() > 0 && mis_cyc_q[0] <= cyc) begin
                abort_run($sformatf("error at %0t: misalign_err pulse is missing", $time));
            end
        end
    end

    // ====================
    // Model and stimulus
    // ====================

    // Quadword 0 of the line sits in its low 64 bits
    function automatic mmio_pkg::mmio_qword_t model_read(input mmio_pkg::mmio_addr_t addr);
        if (addr == 0) begin
            return mmio_pkg::AFU_ID;
        end else if (addr < NUM_CSRS) begin
            return csr_m[addr];
        end else if (addr >= mmio_pkg::LINE_BASE && addr < mmio_pkg::LINE_BASE + 8) begin
            return line_m.line[(addr - mmio_pkg::LINE_BASE) * 64 +: 64];
        end
        return '0;
    endfunction

    function automatic mmio_pkg::mmio_line_u rand_line();
        mmio_pkg::mmio_line_u l;
        for (int i = 0; i < 8; i++) begin
            l.qwords[i] = {$urandom, $urandom};
        end
        return l;
    endfunction

    // Request driven at edge N, which is base + 1 in counter terms
    task automatic send_req(input logic write, input logic is512,
                            input mmio_pkg::mmio_addr_t addr, input mmio_pkg::mmio_line_u data);
        int unsigned base;
        @(posedge clk);
        base = cyc;
        req_valid <= 1'b1;
        req_write <= write;
        req_is512 <= is512;
        req_addr  <= addr;
        req_tid   <= next_tid;
        req_data  <= data;
        if (!is512 && !write) begin
            exp_tid_q.push_back(next_tid);
            exp_data_q.push_back(model_read(addr));
            exp_cyc_q.push_back(base + 4);
        end else if (!is512) begin
            // ID register and line window ignore 64-bit writes
            if (addr != 0 && addr < NUM_CSRS) begin
                csr_m[addr] = data.line[63:0];
            end
        end else if (!write) begin
            bad_cyc_q.push_back(base + 2);
        end else begin
            if (addr % 8 != 0) begin
                mis_cyc_q.push_back(base + 3);
            end
            if (addr == mmio_pkg::LINE_BASE) begin
                line_m = data;
            end
        end
        next_tid = next_tid + 1'b1;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    initial begin
        int unsigned          wait_cnt;
        int unsigned          kind;
        mmio_pkg::mmio_addr_t addr;
        void'($urandom(32'h5f28));
        clk       = 1'b0;
        rst_n     = 1'b0;
        cyc       = 0;
        next_tid  = '0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_is512 = 1'b0;
        req_addr  = '0;
        req_tid   = '0;
        req_data  = '0;
        line_m    = '0;
        for (int i = 0; i < NUM_CSRS; i++) begin
            csr_m[i] = '0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        idle_cycle();

        // Directed start: ID register, scratch CSR, line window, errors
        send_req(1'b1, 1'b0, 16'd0, rand_line());
        send_req(1'b0, 1'b0, 16'd0, '0);
        send_req(1'b1, 1'b0, 16'd5, rand_line());
        send_req(1'b0, 1'b0, 16'd5, '0);
        send_req(1'b1, 1'b1, mmio_pkg::LINE_BASE, rand_line());
        for (int q = 0; q < 8; q++) begin
            send_req(1'b0, 1'b0, mmio_pkg::mmio_addr_t'(mmio_pkg::LINE_BASE + q), '0);
        end
        send_req(1'b0, 1'b0, 16'd40, '0);
        send_req(1'b0, 1'b1, 16'd8, '0);
        send_req(1'b1, 1'b1, 16'd19, rand_line());
        send_req(1'b0, 1'b0, 16'd19, '0);
        idle_cycle();

        // Random mix, one in five cycles left idle
        for (int n = 0; n < N_RANDOM; n++) begin
            kind = $urandom_range(0, 9);
            addr = 16'($urandom_range(0, 31));
            if (kind < 2) begin
                idle_cycle();
            end else if (kind < 5) begin
                send_req(1'b0, 1'b0, addr, '0);
            end else if (kind < 8) begin
                send_req(1'b1, 1'b0, addr, rand_line());
            end else if (kind < 9) begin
                if ($urandom_range(0, 2) == 0) begin
                    addr = mmio_pkg::LINE_BASE;
                end
                send_req(1'b1, 1'b1, addr, rand_line());
            end else begin
                send_req(1'b0, 1'b1, addr, '0);
            end
        end
        idle_cycle();

        wait_cnt = 0;
        while ((exp_cyc_q.size() + bad_cyc_q.size() + mis_cyc_q.size()) > 0 &&
               wait_cnt < DRAIN_MAX) begin
            @(posedge clk);
            wait_cnt++;
        end
        if ((exp_cyc_q.size() + bad_cyc_q.size() + mis_cyc_q.size()) > 0) begin
            abort_run("timeout while waiting for outstanding responses and error pulses");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule
